//--- Makefile
TOP = tb_cpu

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module cpu

clean:
	rm -rf obj_dir

//--- cpu.sv
// cpu top: multi-cycle rv64i core with sequencer, stages and register file
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu (
  input  wire                  clk,
  input  wire                  rst_n_i,
  input  wire                  if_ready_i,
  input  wire [`CPU_XLEN-1:0]  if_data_read_i,
  input  wire [1:0]            if_resp_i,
  output wire                  if_valid_o,
  output wire [`CPU_XLEN-1:0]  if_addr_o,
  output wire                  commit_valid_o,
  output wire [`CPU_XLEN-1:0]  commit_pc_o,
  output wire [4:0]            commit_rd_o,
  output wire                  commit_rd_wen_o,
  output wire [`CPU_XLEN-1:0]  commit_wdata_o,
  output wire                  halt_o
);

  // sequencer controls
  wire                  fetched_req;
  wire                  fetched_ack;
  wire                  fetch_en;
  wire                  decode_en;
  wire                  exec_en;
  wire                  pc_load;
  wire                  rf_wen;

  // fetch results
  wire [`CPU_XLEN-1:0]  if_pc;
  wire [31:0]           if_inst;
  wire                  if_bus_err;

  // decode results
  wire [4:0]            id_rs1;
  wire [4:0]            id_rs2;
  wire [4:0]            id_rd;
  wire                  id_rd_wen;
  cpu_pkg::alu_op_e     id_alu_op;
  wire [`CPU_XLEN-1:0]  id_op1;
  wire [`CPU_XLEN-1:0]  id_op2;
  wire [`CPU_XLEN-1:0]  id_imm;
  wire                  id_is_jal;
  wire                  id_is_branch;
  wire                  id_branch_ne;
  wire                  id_illegal;

  wire [`CPU_XLEN-1:0]  rf_rs1_data;
  wire [`CPU_XLEN-1:0]  rf_rs2_data;
  wire [`CPU_XLEN-1:0]  ex_result;
  wire [`CPU_XLEN-1:0]  ex_next_pc;

  stage_ctrl u_stage_ctrl (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .fetched_req_i  (fetched_req),
    .fetched_ack_o  (fetched_ack),
    .bus_err_i      (if_bus_err),
    .illegal_i      (id_illegal),
    .rd_wen_i       (id_rd_wen),
    .fetch_en_o     (fetch_en),
    .decode_en_o    (decode_en),
    .exec_en_o      (exec_en),
    .wb_en_o        (),
    .pc_load_o      (pc_load),
    .rf_wen_o       (rf_wen),
    .commit_valid_o (commit_valid_o),
    .halt_o         (halt_o)
  );

  if_stage u_if_stage (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .fetch_en_i     (fetch_en),
    .fetched_req_o  (fetched_req),
    .fetched_ack_i  (fetched_ack),
    .if_valid_o     (if_valid_o),
    .if_addr_o      (if_addr_o),
    .if_ready_i     (if_ready_i),
    .if_data_read_i (if_data_read_i),
    .if_resp_i      (if_resp_i),
    .pc_load_i      (pc_load),
    .next_pc_i      (ex_next_pc),
    .pc_o           (if_pc),
    .inst_o         (if_inst),
    .bus_err_o      (if_bus_err)
  );

  id_stage u_id_stage (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .decode_en_i    (decode_en),
    .inst_i         (if_inst),
    .rs1_o          (id_rs1),
    .rs2_o          (id_rs2),
    .rs1_data_i     (rf_rs1_data),
    .rs2_data_i     (rf_rs2_data),
    .rd_o           (id_rd),
    .rd_wen_o       (id_rd_wen),
    .alu_op_o       (id_alu_op),
    .op1_o          (id_op1),
    .op2_o          (id_op2),
    .imm_o          (id_imm),
    .is_jal_o       (id_is_jal),
    .is_branch_o    (id_is_branch),
    .branch_ne_o    (id_branch_ne),
    .illegal_o      (id_illegal)
  );

  exe_stage u_exe_stage (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .exec_en_i      (exec_en),
    .pc_i           (if_pc),
    .alu_op_i       (id_alu_op),
    .op1_i          (id_op1),
    .op2_i          (id_op2),
    .imm_i          (id_imm),
    .is_jal_i       (id_is_jal),
    .is_branch_i    (id_is_branch),
    .branch_ne_i    (id_branch_ne),
    .result_o       (ex_result),
    .next_pc_o      (ex_next_pc)
  );

  regfile u_regfile (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .rs1_i          (id_rs1),
    .rs2_i          (id_rs2),
    .rs1_data_o     (rf_rs1_data),
    .rs2_data_o     (rf_rs2_data),
    .rd_i           (id_rd),
    .rd_wen_i       (rf_wen),
    .rd_data_i      (ex_result)
  );

  // commit port shows the retiring instruction
  assign commit_pc_o     = if_pc;
  assign commit_rd_o     = id_rd;
  assign commit_rd_wen_o = id_rd_wen;
  assign commit_wdata_o  = ex_result;

endmodule

`default_nettype wire

//--- cpu_cfg.svh
// cpu configuration: data width, reset pc and register count
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and address width
`define CPU_XLEN 64

// pc after reset
`define CPU_RESET_PC 64'h0

// integer registers
`define CPU_NREGS 32

`endif

//--- cpu_pkg.sv
// cpu package: sequencer states, alu operations and rv64i major opcodes
`default_nettype none

package cpu_pkg;

  // sequencer states, one instruction at a time
  typedef enum logic [2:0] {
    S_FETCH     = 3'd0,
    S_DECODE    = 3'd1,
    S_EXECUTE   = 3'd2,
    S_WRITEBACK = 3'd3,
    S_HALT      = 3'd4
  } ctrl_state_e;

  // alu operations
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

//--- cpu_properties.sv
// cpu protocol checks: instruction bus hold, single-cycle commit and sticky halt
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_properties (
  input wire                 clk,
  input wire                 rst_n_i,
  input wire                 valid_i,
  input wire                 ready_i,
  input wire [`CPU_XLEN-1:0] addr_i,
  input wire                 commit_i,
  input wire                 halt_i
);

  // request held with a stable address until ready
  req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    (valid_i && !ready_i) |=> (valid_i && $stable(addr_i)))
    else $error("instruction request changed before ready");

  commit_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    commit_i |=> !commit_i)
    else $error("commit strobe lasted two cycles");

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
    halt_i |=> halt_i)
    else $error("halt dropped before reset");

  // a halted core is quiet
  halt_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
    halt_i |-> (!valid_i && !commit_i))
    else $error("fetch or commit while halted");

endmodule

bind cpu cpu_properties u_cpu_properties (
  .clk      (clk),
  .rst_n_i  (rst_n_i),
  .valid_i  (if_valid_o),
  .ready_i  (if_ready_i),
  .addr_i   (if_addr_o),
  .commit_i (commit_valid_o),
  .halt_i   (halt_o)
);

`default_nettype wire

//--- exe_stage.sv
// execute stage: alu, branch decision and next pc
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module exe_stage (
  input  wire                    clk,
  input  wire                    rst_n_i,
  input  wire                    exec_en_i,
  input  wire [`CPU_XLEN-1:0]    pc_i,
  input  cpu_pkg::alu_op_e       alu_op_i,
  input  wire [`CPU_XLEN-1:0]    op1_i,
  input  wire [`CPU_XLEN-1:0]    op2_i,
  input  wire [`CPU_XLEN-1:0]    imm_i,
  input  wire                    is_jal_i,
  input  wire                    is_branch_i,
  input  wire                    branch_ne_i,
  output logic [`CPU_XLEN-1:0]   result_o,
  output logic [`CPU_XLEN-1:0]   next_pc_o
);

  logic [`CPU_XLEN-1:0] alu_res;
  logic [`CPU_XLEN-1:0] pc_plus4;
  logic [`CPU_XLEN-1:0] pc_target;
  logic                 equal;
  logic                 taken;

  always_comb begin
    case (alu_op_i)
      cpu_pkg::ALU_ADD:    alu_res = op1_i + op2_i;
      cpu_pkg::ALU_SUB:    alu_res = op1_i - op2_i;
      cpu_pkg::ALU_AND:    alu_res = op1_i & op2_i;
      cpu_pkg::ALU_OR:     alu_res = op1_i | op2_i;
      cpu_pkg::ALU_XOR:    alu_res = op1_i ^ op2_i;
      cpu_pkg::ALU_SLT: begin
        alu_res = {{(`CPU_XLEN-1){1'b0}}, ($signed(op1_i) < $signed(op2_i))};
      end
      cpu_pkg::ALU_PASS_B: alu_res = op2_i;
      default:             alu_res = op1_i + op2_i;
    endcase
  end

  assign pc_plus4  = pc_i + `CPU_XLEN'd4;
  assign pc_target = pc_i + imm_i;
  assign equal     = (op1_i == op2_i);

  // bne is taken on inequality, beq on equality
  assign taken = is_jal_i | (is_branch_i & (equal ^ branch_ne_i));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      next_pc_o <= `CPU_RESET_PC;
    end else if (exec_en_i) begin
      next_pc_o <= taken ? pc_target : pc_plus4;
    end
  end

  // jal links the return address
  always_ff @(posedge clk) begin
    if (exec_en_i) begin
      result_o <= is_jal_i ? pc_plus4 : alu_res;
    end
  end

endmodule

`default_nettype wire

//--- id_stage.sv
// decode stage: field decode, immediate generation and operand capture
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module id_stage (
  input  wire                    clk,
  input  wire                    rst_n_i,
  input  wire                    decode_en_i,
  input  wire [31:0]             inst_i,
  output wire [4:0]              rs1_o,
  output wire [4:0]              rs2_o,
  input  wire [`CPU_XLEN-1:0]    rs1_data_i,
  input  wire [`CPU_XLEN-1:0]    rs2_data_i,
  output logic [4:0]             rd_o,
  output logic                   rd_wen_o,
  output cpu_pkg::alu_op_e       alu_op_o,
  output logic [`CPU_XLEN-1:0]   op1_o,
  output logic [`CPU_XLEN-1:0]   op2_o,
  output logic [`CPU_XLEN-1:0]   imm_o,
  output logic                   is_jal_o,
  output logic                   is_branch_o,
  output logic                   branch_ne_o,
  output logic                   illegal_o
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`CPU_XLEN-1:0] imm_i;
  logic [`CPU_XLEN-1:0] imm_u;
  logic [`CPU_XLEN-1:0] imm_b;
  logic [`CPU_XLEN-1:0] imm_j;

  logic [`CPU_XLEN-1:0] imm_d;
  logic [`CPU_XLEN-1:0] op2_d;
  cpu_pkg::alu_op_e     alu_op_d;
  logic                 rd_wen_d;
  logic                 jal_d;
  logic                 branch_d;
  logic                 illegal_d;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  assign imm_i = {{(`CPU_XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{(`CPU_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_b = {{(`CPU_XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                  inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{(`CPU_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                  inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    imm_d     = imm_i;
    op2_d     = rs2_data_i;
    alu_op_d  = cpu_pkg::ALU_ADD;
    rd_wen_d  = 1'b0;
    jal_d     = 1'b0;
    branch_d  = 1'b0;
    illegal_d = 1'b0;
    case (opcode)
      cpu_pkg::OPC_OP: begin
        rd_wen_d = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op_d = cpu_pkg::ALU_ADD;
          {7'h20, 3'b000}: alu_op_d = cpu_pkg::ALU_SUB;
          {7'h00, 3'b111}: alu_op_d = cpu_pkg::ALU_AND;
          {7'h00, 3'b110}: alu_op_d = cpu_pkg::ALU_OR;
          {7'h00, 3'b100}: alu_op_d = cpu_pkg::ALU_XOR;
          {7'h00, 3'b010}: alu_op_d = cpu_pkg::ALU_SLT;
          default:         illegal_d = 1'b1;
        endcase
      end
      cpu_pkg::OPC_OP_IMM: begin
        // only addi
        rd_wen_d  = 1'b1;
        op2_d     = imm_i;
        illegal_d = (funct3 != 3'b000);
      end
      cpu_pkg::OPC_LUI: begin
        rd_wen_d = 1'b1;
        imm_d    = imm_u;
        op2_d    = imm_u;
        alu_op_d = cpu_pkg::ALU_PASS_B;
      end
      cpu_pkg::OPC_JAL: begin
        rd_wen_d = 1'b1;
        jal_d    = 1'b1;
        imm_d    = imm_j;
      end
      cpu_pkg::OPC_BRANCH: begin
        // beq and bne
        branch_d  = 1'b1;
        imm_d     = imm_b;
        illegal_d = (funct3[2:1] != 2'b00);
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_wen_o    <= 1'b0;
      alu_op_o    <= cpu_pkg::ALU_ADD;
      is_jal_o    <= 1'b0;
      is_branch_o <= 1'b0;
      branch_ne_o <= 1'b0;
      illegal_o   <= 1'b0;
    end else if (decode_en_i) begin
      rd_wen_o    <= rd_wen_d;
      alu_op_o    <= alu_op_d;
      is_jal_o    <= jal_d;
      is_branch_o <= branch_d;
      branch_ne_o <= funct3[0];
      illegal_o   <= illegal_d;
    end
  end

  always_ff @(posedge clk) begin
    if (decode_en_i) begin
      rd_o  <= inst_i[11:7];
      op1_o <= rs1_data_i;
      op2_o <= op2_d;
      imm_o <= imm_d;
    end
  end

endmodule

`default_nettype wire

//--- if_stage.sv
// fetch stage: program counter, instruction bus request and instruction capture
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module if_stage (
  input  wire                    clk,
  input  wire                    rst_n_i,
  input  wire                    fetch_en_i,
  output wire                    fetched_req_o,
  input  wire                    fetched_ack_i,
  output wire                    if_valid_o,
  output wire [`CPU_XLEN-1:0]    if_addr_o,
  input  wire                    if_ready_i,
  input  wire [`CPU_XLEN-1:0]    if_data_read_i,
  input  wire [1:0]              if_resp_i,
  input  wire                    pc_load_i,
  input  wire [`CPU_XLEN-1:0]    next_pc_i,
  output wire [`CPU_XLEN-1:0]    pc_o,
  output wire [31:0]             inst_o,
  output wire                    bus_err_o
);

  logic [`CPU_XLEN-1:0] pc_q;
  logic                 req_q;
  logic                 done_q;
  logic                 err_q;
  logic [31:0]          inst_q;
  logic                 xfer;

  assign xfer = req_q & if_ready_i;

  // pc only moves at writeback
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= `CPU_RESET_PC;
    end else if (pc_load_i) begin
      pc_q <= next_pc_i;
    end
  end

  // bus request, raised right at the pc load or on entry to fetch
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else if (xfer) begin
      req_q <= 1'b0;
    end else if (pc_load_i || (fetch_en_i && !req_q && !done_q)) begin
      req_q <= 1'b1;
    end
  end

  // fetched_req held until the sequencer takes it
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else if (xfer) begin
      done_q <= 1'b1;
      err_q  <= |if_resp_i;
    end else if (done_q && fetched_ack_i) begin
      done_q <= 1'b0;
    end
  end

  // address bit 2 picks the half of the beat
  always_ff @(posedge clk) begin
    if (xfer) begin
      inst_q <= pc_q[2] ? if_data_read_i[63:32] : if_data_read_i[31:0];
    end
  end

  assign if_valid_o    = req_q;
  assign if_addr_o     = pc_q;
  assign fetched_req_o = done_q;
  assign bus_err_o     = err_q;
  assign pc_o          = pc_q;
  assign inst_o        = inst_q;

endmodule

`default_nettype wire

//--- regfile.sv
// register file: 32 x 64-bit, two async read ports, one sync write port
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module regfile (
  input  wire                          clk,
  input  wire                          rst_n_i,
  input  wire [$clog2(`CPU_NREGS)-1:0] rs1_i,
  input  wire [$clog2(`CPU_NREGS)-1:0] rs2_i,
  output wire [`CPU_XLEN-1:0]          rs1_data_o,
  output wire [`CPU_XLEN-1:0]          rs2_data_o,
  input  wire [$clog2(`CPU_NREGS)-1:0] rd_i,
  input  wire                          rd_wen_i,
  input  wire [`CPU_XLEN-1:0]          rd_data_i
);

  logic [`CPU_XLEN-1:0] regs [0:`CPU_NREGS-1];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wen_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
cpu_pkg.sv
if_stage.sv
id_stage.sv
exe_stage.sv
regfile.sv
stage_ctrl.sv
cpu.sv
cpu_properties.sv
tb_cpu.sv

//--- stage_ctrl.sv
// stage sequencer: steps fetch, decode, execute, writeback and handles halt
`timescale 1ns/100ps
`default_nettype none

module stage_ctrl (
  input  wire   clk,
  input  wire   rst_n_i,
  input  wire   fetched_req_i,
  output logic  fetched_ack_o,
  input  wire   bus_err_i,
  input  wire   illegal_i,
  input  wire   rd_wen_i,
  output logic  fetch_en_o,
  output logic  decode_en_o,
  output logic  exec_en_o,
  output logic  wb_en_o,
  output logic  pc_load_o,
  output logic  rf_wen_o,
  output logic  commit_valid_o,
  output logic  halt_o
);

  cpu_pkg::ctrl_state_e state_q;
  cpu_pkg::ctrl_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cpu_pkg::S_FETCH: begin
        if (fetched_req_i) begin
          state_d = bus_err_i ? cpu_pkg::S_HALT : cpu_pkg::S_DECODE;
        end
      end
      cpu_pkg::S_DECODE: state_d = cpu_pkg::S_EXECUTE;
      // illegal flag is registered by decode, seen here
      cpu_pkg::S_EXECUTE: begin
        state_d = illegal_i ? cpu_pkg::S_HALT : cpu_pkg::S_WRITEBACK;
      end
      cpu_pkg::S_WRITEBACK: state_d = cpu_pkg::S_FETCH;
      cpu_pkg::S_HALT:      state_d = cpu_pkg::S_HALT;
      default:              state_d = cpu_pkg::S_HALT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= cpu_pkg::S_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  assign fetch_en_o    = (state_q == cpu_pkg::S_FETCH);
  assign fetched_ack_o = fetch_en_o & fetched_req_i;
  assign decode_en_o   = (state_q == cpu_pkg::S_DECODE);
  assign exec_en_o     = (state_q == cpu_pkg::S_EXECUTE);
  assign wb_en_o       = (state_q == cpu_pkg::S_WRITEBACK);
  assign halt_o        = (state_q == cpu_pkg::S_HALT);

  // writeback retires the instruction and moves the pc
  assign pc_load_o      = wb_en_o;
  assign commit_valid_o = wb_en_o;
  assign rf_wen_o       = wb_en_o & rd_wen_i;

endmodule

`default_nettype wire

//--- tb_cpu.sv
// cpu testbench with a random program, a bus responder with wait states and a reference model
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu;

  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_SLT  = 5;
  localparam int K_ADDI = 6;
  localparam int K_LUI  = 7;
  localparam int K_JAL  = 8;
  localparam int K_BEQ  = 9;
  localparam int K_BNE  = 10;
  localparam int K_ILL  = 11;

  localparam int N_COMMITS  = 400;
  // 400 commits of at most 8 cycles each plus resets and halt phases
  localparam int MAX_CYCLES = 6000;

  logic                 clk;
  logic                 rst_n_i;
  logic                 if_ready_i;
  logic [`CPU_XLEN-1:0] if_data_read_i;
  logic [1:0]           if_resp_i;
  wire                  if_valid_o;
  wire  [`CPU_XLEN-1:0] if_addr_o;
  wire                  commit_valid_o;
  wire  [`CPU_XLEN-1:0] commit_pc_o;
  wire  [4:0]           commit_rd_o;
  wire                  commit_rd_wen_o;
  wire  [`CPU_XLEN-1:0] commit_wdata_o;
  wire                  halt_o;

  integer               seed = 20547;
  // program words and the fields they were built from
  logic [31:0]          prog  [0:1023];
  int                   kind  [0:1023];
  logic [4:0]           f_rd  [0:1023];
  logic [4:0]           f_rs1 [0:1023];
  logic [4:0]           f_rs2 [0:1023];
  logic [`CPU_XLEN-1:0] f_imm [0:1023];
  logic [`CPU_XLEN-1:0] mregs [0:31];
  logic [`CPU_XLEN-1:0] mpc;
  int                   commit_count;
  int                   cycles;
  bit                   err_mode;
  bit                   busy;
  int                   wait_left;
  logic [31:0]          rv;

  cpu u_cpu (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .if_ready_i      (if_ready_i),
    .if_data_read_i  (if_data_read_i),
    .if_resp_i       (if_resp_i),
    .if_valid_o      (if_valid_o),
    .if_addr_o       (if_addr_o),
    .commit_valid_o  (commit_valid_o),
    .commit_pc_o     (commit_pc_o),
    .commit_rd_o     (commit_rd_o),
    .commit_rd_wen_o (commit_rd_wen_o),
    .commit_wdata_o  (commit_wdata_o),
    .halt_o          (halt_o)
  );

  always #50 clk = ~clk;

  task automatic fail_stop;
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    fail_stop();
  endtask

  task automatic abort_run(input string reason);
    $display("ERROR %s", reason);
    fail_stop();
  endtask

  // jumps of 1 to 8 words ahead wrap inside the 4 KiB program
  task automatic build_program;
    int          a;
    int          k;
    int          tw;
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] ob;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  f7;
    logic [2:0]  f3;
    for (a = 0; a < 1024; a++) begin
      r   = $random(seed);
      r2  = $random(seed);
      k   = (a == 1023) ? K_JAL : int'(r[7:0]) % 11;
      rd  = r[12:8];
      rs1 = r[17:13];
      rs2 = r[22:18];
      tw  = (a + 1 + int'(r2[2:0])) % 1024;
      ob  = (tw - a) * 4;
      f7  = 7'h00;
      f3  = 3'b000;
      case (k)
        K_SUB:   f7 = 7'h20;
        K_AND:   f3 = 3'b111;
        K_OR:    f3 = 3'b110;
        K_XOR:   f3 = 3'b100;
        K_SLT:   f3 = 3'b010;
        K_BNE:   f3 = 3'b001;
        default: f3 = 3'b000;
      endcase
      f_imm[a] = {{32{ob[31]}}, ob};
      case (k)
        K_ADDI: begin
          prog[a]  = {r2[31:20], rs1, 3'b000, rd, cpu_pkg::OPC_OP_IMM};
          f_imm[a] = {{52{r2[31]}}, r2[31:20]};
        end
        K_LUI: begin
          prog[a]  = {r2[31:12], rd, cpu_pkg::OPC_LUI};
          f_imm[a] = {{32{r2[31]}}, r2[31:12], 12'h000};
        end
        K_JAL:   prog[a] = {ob[20], ob[10:1], ob[11], ob[19:12], rd, cpu_pkg::OPC_JAL};
        K_BEQ, K_BNE: begin
          prog[a] = {ob[12], ob[10:5], rs2, rs1, f3, ob[4:1], ob[11], cpu_pkg::OPC_BRANCH};
        end
        default: prog[a] = {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
      endcase
      kind[a]  = k;
      f_rd[a]  = rd;
      f_rs1[a] = rs1;
      f_rs2[a] = rs2;
    end
  endtask

  task automatic apply_reset;
    int i;
    @(posedge clk);
    #1 rst_n_i = 1'b0;
    for (i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    mpc          = `CPU_RESET_PC;
    commit_count = 0;
    repeat (10) @(posedge clk);
    #1 rst_n_i = 1'b1;
  endtask

  // reference step for one retired instruction
  task automatic check_commit;
    int                   k;
    logic [9:0]           idx;
    logic [`CPU_XLEN-1:0] a;
    logic [`CPU_XLEN-1:0] b;
    logic [`CPU_XLEN-1:0] exp_wdata;
    logic [`CPU_XLEN-1:0] npc;
    logic                 exp_wen;
    idx       = mpc[11:2];
    k         = kind[idx];
    a         = mregs[f_rs1[idx]];
    b         = mregs[f_rs2[idx]];
    exp_wen   = 1'b1;
    exp_wdata = '0;
    npc       = mpc + 64'd4;
    assert (k != K_ILL) else abort_run("an instruction committed after the illegal opcode");
    case (k)
      K_ADD:  exp_wdata = a + b;
      K_SUB:  exp_wdata = a - b;
      K_AND:  exp_wdata = a & b;
      K_OR:   exp_wdata = a | b;
      K_XOR:  exp_wdata = a ^ b;
      K_SLT:  exp_wdata = {63'b0, $signed(a) < $signed(b)};
      K_ADDI: exp_wdata = a + f_imm[idx];
      K_LUI:  exp_wdata = f_imm[idx];
      K_JAL: begin
        exp_wdata = mpc + 64'd4;
        npc       = mpc + f_imm[idx];
      end
      default: begin
        exp_wen = 1'b0;
        if ((a == b) != (k == K_BNE)) begin
          npc = mpc + f_imm[idx];
        end
      end
    endcase
    assert (commit_pc_o == mpc) else report_mismatch("commit_pc_o", commit_pc_o, mpc);
    assert (commit_rd_wen_o == exp_wen)
      else report_mismatch("commit_rd_wen_o", 64'(commit_rd_wen_o), 64'(exp_wen));
    if (exp_wen) begin
      assert (commit_rd_o == f_rd[idx])
        else report_mismatch("commit_rd_o", 64'(commit_rd_o), 64'(f_rd[idx]));
      assert (commit_wdata_o == exp_wdata)
        else report_mismatch("commit_wdata_o", commit_wdata_o, exp_wdata);
      if (f_rd[idx] != 5'd0) begin
        mregs[f_rd[idx]] = exp_wdata;
      end
    end
    mpc = npc;
    commit_count++;
  endtask

  // bus responder with 0 to 3 wait states per request
  always @(posedge clk) begin
    #1;
    if (!if_valid_o) begin
      busy       = 1'b0;
      if_ready_i = 1'b0;
      if_resp_i  = 2'b00;
    end else begin
      if (!busy) begin
        busy      = 1'b1;
        rv        = $random(seed);
        wait_left = int'(rv[1:0]);
      end
      if (wait_left == 0) begin
        if_ready_i     = 1'b1;
        if_data_read_i = {prog[{if_addr_o[11:3], 1'b1}], prog[{if_addr_o[11:3], 1'b0}]};
        if_resp_i      = err_mode ? 2'b01 : 2'b00;
      end else begin
        if_ready_i = 1'b0;
        wait_left--;
      end
    end
  end

  // mid-cycle monitor of fetch addresses and commits
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (if_valid_o) begin
        assert (if_addr_o == mpc) else report_mismatch("if_addr_o", if_addr_o, mpc);
      end
      if (commit_valid_o) begin
        check_commit();
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      abort_run("timeout, the run did not finish within 6000 cycles");
    end
  end

  initial begin
    clk            = 1'b0;
    rst_n_i        = 1'b0;
    if_ready_i     = 1'b0;
    if_data_read_i = '0;
    if_resp_i      = 2'b00;
    err_mode       = 1'b0;
    busy           = 1'b0;
    wait_left      = 0;
    commit_count   = 0;
    cycles         = 0;
    build_program();
    apply_reset();

    wait (commit_count == N_COMMITS);
    // opcode 7f is outside the subset
    prog[mpc[11:2]] = 32'h0000_007f;
    kind[mpc[11:2]] = K_ILL;
    while (!halt_o) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      assert (halt_o && !if_valid_o)
        else abort_run("halt_o dropped or a fetch started after the illegal opcode");
    end

    err_mode = 1'b1;
    apply_reset();
    while (!halt_o) @(negedge clk);
    assert (commit_count == 0) else abort_run("an instruction committed despite the bus error");

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
